// ==== source/rv_pkg.sv ====
/* rv core package
   widths, opcodes, ALU operation codes and the instruction format views */
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // major opcodes of the kept instruction classes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B    // LUI result is the immediate itself
    } alu_op_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // branch offset is scattered over the word
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage

`default_nettype wire

// ==== source/exec_if.sv ====
/* execute bus
   decoded operands and class flags from decode to the execute and writeback units */
`default_nettype none
`timescale 1ns/100ps

interface exec_if import rv_pkg::*; ();

    logic                  exec_valid;    // one-cycle strobe per instruction
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       rs1_val;
    logic [XLEN-1:0]       rs2_val;
    logic [XLEN-1:0]       imm;
    alu_op_t               alu_op;
    logic [2:0]            funct3;
    logic                  is_op;         // register-register arithmetic
    logic                  is_op_imm;
    logic                  is_lui;
    logic                  is_auipc;
    logic                  is_branch;
    logic                  is_jal;
    logic                  is_jalr;
    logic [REG_ADDR_W-1:0] rd;

    modport source (
        output exec_valid, pc, rs1_val, rs2_val, imm, alu_op, funct3,
        output is_op, is_op_imm, is_lui, is_auipc, is_branch, is_jal, is_jalr, rd
    );

    modport sink (
        input exec_valid, pc, rs1_val, rs2_val, imm, alu_op, funct3,
        input is_op, is_op_imm, is_lui, is_auipc, is_branch, is_jal, is_jalr, rd
    );

endinterface

`default_nettype wire

// ==== source/fetch_unit.sv ====
/* fetch unit
   holds the pc and runs the four-phase req/ack instruction port */
`default_nettype none
`timescale 1ns/100ps

module fetch_unit import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            imem_ack,
    input  logic [31:0]     imem_data,
    input  logic            pc_load,
    input  logic [XLEN-1:0] next_pc,
    output logic            imem_req,
    output logic [XLEN-1:0] imem_addr,
    output logic            instr_valid,
    output logic [31:0]     instr,
    output logic [XLEN-1:0] instr_pc
);

    typedef enum logic [1:0] {
        ST_RELEASE,    // wait for ack low before a new request
        ST_REQUEST,    // req high, waiting for ack
        ST_RETIRE      // instruction in flight
    } fetch_state_t;

    fetch_state_t    state;
    logic [XLEN-1:0] pc;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= ST_RELEASE;
            imem_req    <= 1'b0;
            instr_valid <= 1'b0;
            pc          <= RESET_PC;
        end else begin
            instr_valid <= 1'b0;
            case (state)
                ST_RELEASE: begin
                    if (!imem_ack) begin
                        imem_req <= 1'b1;
                        state    <= ST_REQUEST;
                    end
                end
                ST_REQUEST: begin
                    if (imem_ack) begin
                        imem_req    <= 1'b0;
                        instr_valid <= 1'b1;
                        state       <= ST_RETIRE;
                    end
                end
                ST_RETIRE: begin
                    if (pc_load) begin
                        pc <= next_pc;
                        // skip the release state when ack is already low
                        if (!imem_ack) begin
                            imem_req <= 1'b1;
                            state    <= ST_REQUEST;
                        end else begin
                            state <= ST_RELEASE;
                        end
                    end
                end
                default: state <= ST_RELEASE;
            endcase
        end
    end

    // word capture
    always_ff @(posedge clk) begin
        if (state == ST_REQUEST && imem_ack) begin
            instr <= imem_data;
        end
    end

    assign imem_addr = pc;
    assign instr_pc  = pc;    // pc stays put until the next pc_load

    // req only drops after an ack was seen
    a_req_fall_after_ack: assert property (
        @(posedge clk) disable iff (reset) $fell(imem_req) |-> $past(imem_ack)
    );

    // req only rises once the previous ack is gone
    a_req_rise_ack_low: assert property (
        @(posedge clk) disable iff (reset) $rose(imem_req) |-> !$past(imem_ack)
    );

endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
/* decode stage
   classifies the instruction, builds the immediate, reads the register file */
`default_nettype none
`timescale 1ns/100ps

module decode_stage import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  instr_valid,
    input  logic [31:0]           instr,
    input  logic [XLEN-1:0]       instr_pc,
    input  logic                  reg_we,
    input  logic [REG_ADDR_W-1:0] reg_waddr,
    input  logic [XLEN-1:0]       reg_wdata,
    exec_if.source                ex
);

    instr_u          iw;
    logic [6:0]      opcode;
    logic            op_r, op_imm, op_lui, op_auipc, op_branch, op_jal, op_jalr;
    logic [XLEN-1:0] imm;
    alu_op_t         alu_op;
    logic [XLEN-1:0] rs1_rd, rs2_rd;

    logic [XLEN-1:0] regs [NUM_REGS];

    assign iw     = instr;
    assign opcode = iw.r.opcode;

    assign op_r      = (opcode == OPC_OP);
    assign op_imm    = (opcode == OPC_OP_IMM);
    assign op_lui    = (opcode == OPC_LUI);
    assign op_auipc  = (opcode == OPC_AUIPC);
    assign op_branch = (opcode == OPC_BRANCH);
    assign op_jal    = (opcode == OPC_JAL);
    assign op_jalr   = (opcode == OPC_JALR);

    always_comb begin
        if (op_imm || op_jalr) begin
            imm = {{20{iw.i.imm[11]}}, iw.i.imm};
        end else if (op_branch) begin
            imm = {{20{iw.b.imm_12}}, iw.b.imm_11, iw.b.imm_10_5, iw.b.imm_4_1, 1'b0};
        end else if (op_lui || op_auipc) begin
            imm = {iw.u.imm_31_12, 12'b0};
        end else if (op_jal) begin
            imm = {{12{iw.j.imm_20}}, iw.j.imm_19_12, iw.j.imm_11, iw.j.imm_10_1, 1'b0};
        end else begin
            imm = '0;
        end
    end

    // funct7 bit 5 sits at instr[30] for both R and shift-immediate words
    always_comb begin
        alu_op = ALU_ADD;    // AUIPC and everything else
        if (op_lui) begin
            alu_op = ALU_PASS_B;
        end else if (op_r || op_imm) begin
            case (iw.r.funct3)
                3'b000:  alu_op = (op_r && iw.r.funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = iw.r.funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    // x0 is never written and reads as zero
    always_ff @(posedge clk) begin
        if (reg_we && reg_waddr != '0) begin
            regs[reg_waddr] <= reg_wdata;
        end
    end

    assign rs1_rd = (iw.r.rs1 == '0) ? '0 : regs[iw.r.rs1];
    assign rs2_rd = (iw.r.rs2 == '0) ? '0 : regs[iw.r.rs2];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex.exec_valid <= 1'b0;
        end else begin
            ex.exec_valid <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            ex.pc        <= instr_pc;
            ex.rs1_val   <= rs1_rd;
            ex.rs2_val   <= rs2_rd;
            ex.imm       <= imm;
            ex.alu_op    <= alu_op;
            ex.funct3    <= iw.r.funct3;
            ex.is_op     <= op_r;
            ex.is_op_imm <= op_imm;
            ex.is_lui    <= op_lui;
            ex.is_auipc  <= op_auipc;
            ex.is_branch <= op_branch;
            ex.is_jal    <= op_jal;
            ex.is_jalr   <= op_jalr;
            ex.rd        <= iw.r.rd;
        end
    end

endmodule

`default_nettype wire

// ==== source/alu_unit.sv ====
/* integer ALU with operand selection */
`default_nettype none
`timescale 1ns/100ps

module alu_unit import rv_pkg::*; (
    exec_if.sink            ex,
    output logic [XLEN-1:0] alu_result
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;

    assign op_a  = ex.is_auipc ? ex.pc : ex.rs1_val;
    assign op_b  = ex.is_op ? ex.rs2_val : ex.imm;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ex.alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SLT: begin
                alu_result = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, (op_a < op_b)};
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> shamt;
            ALU_SRA:  alu_result = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            ALU_PASS_B: alu_result = op_b;
            default:  alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/branch_unit.sv ====
/* branch unit
   evaluates branch conditions and forms jump targets */
`default_nettype none
`timescale 1ns/100ps

module branch_unit import rv_pkg::*; (
    exec_if.sink            ex,
    output logic            take_jump,
    output logic [XLEN-1:0] jump_target
);

    logic            cond;
    logic [XLEN-1:0] base;
    logic [XLEN-1:0] sum;

    always_comb begin
        case (ex.funct3)
            3'b000:  cond = (ex.rs1_val == ex.rs2_val);    // beq
            3'b001:  cond = (ex.rs1_val != ex.rs2_val);
            3'b100:  cond = ($signed(ex.rs1_val) < $signed(ex.rs2_val));
            3'b101:  cond = ($signed(ex.rs1_val) >= $signed(ex.rs2_val));
            3'b110:  cond = (ex.rs1_val < ex.rs2_val);
            3'b111:  cond = (ex.rs1_val >= ex.rs2_val);    // bgeu
            default: cond = 1'b0;
        endcase
    end

    assign take_jump = ex.is_jal || ex.is_jalr || (ex.is_branch && cond);

    // JALR is register relative, the rest pc relative
    assign base = ex.is_jalr ? ex.rs1_val : ex.pc;
    assign sum  = base + ex.imm;

    // fetch stays word aligned
    assign jump_target = {sum[XLEN-1:2], 2'b00};

endmodule

`default_nettype wire

// ==== source/writeback_unit.sv ====
/* writeback unit
   registers the register write, next pc and the retire record */
`default_nettype none
`timescale 1ns/100ps

module writeback_unit import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [XLEN-1:0]       alu_result,
    input  logic                  take_jump,
    input  logic [XLEN-1:0]       jump_target,
    exec_if.sink                  ex,
    output logic                  reg_we,
    output logic [REG_ADDR_W-1:0] reg_waddr,
    output logic [XLEN-1:0]       reg_wdata,
    output logic                  pc_load,
    output logic [XLEN-1:0]       next_pc,
    output logic                  retire_valid,
    output logic [XLEN-1:0]       retire_pc,
    output logic [REG_ADDR_W-1:0] retire_rd,
    output logic                  retire_we,
    output logic [XLEN-1:0]       retire_wdata
);

    logic [XLEN-1:0] seq_pc;
    logic            wr_en;
    logic [XLEN-1:0] wr_data;

    assign seq_pc = ex.pc + XLEN'(4);

    always_comb begin
        wr_en   = 1'b0;
        wr_data = '0;
        if (ex.is_jal || ex.is_jalr) begin
            wr_en   = 1'b1;
            wr_data = seq_pc;    // link address
        end else if (ex.is_op || ex.is_op_imm || ex.is_lui || ex.is_auipc) begin
            wr_en   = 1'b1;
            wr_data = alu_result;
        end
        if (ex.rd == '0) begin
            wr_en   = 1'b0;
            wr_data = '0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
        end else begin
            retire_valid <= ex.exec_valid;
            retire_we    <= ex.exec_valid && wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (ex.exec_valid) begin
            retire_pc    <= ex.pc;
            retire_rd    <= ex.rd;
            retire_wdata <= wr_data;
            next_pc      <= take_jump ? jump_target : seq_pc;
        end
    end

    // register write and pc load share the retire edge
    assign reg_we    = retire_we;
    assign reg_waddr = retire_rd;
    assign reg_wdata = retire_wdata;
    assign pc_load   = retire_valid;

    // pc alignment is kept from reset pc through every jump target
    a_retire_pc_aligned: assert property (
        @(posedge clk) disable iff (reset) retire_valid |-> (retire_pc[1:0] == 2'b00)
    );

endmodule

`default_nettype wire

// ==== source/rv_core.sv ====
/* rv32i core top level
   one instruction in flight, fetched over a four-phase memory port */
`default_nettype none
`timescale 1ns/100ps

module rv_core import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 32'h8000_0000
) (
    input  logic                  clk,
    input  logic                  reset,
    output logic                  imem_req,
    output logic [XLEN-1:0]       imem_addr,
    input  logic                  imem_ack,
    input  logic [31:0]           imem_data,
    output logic                  retire_valid,
    output logic [XLEN-1:0]       retire_pc,
    output logic [REG_ADDR_W-1:0] retire_rd,
    output logic                  retire_we,
    output logic [XLEN-1:0]       retire_wdata
);

    logic                  instr_valid;
    logic [31:0]           instr;
    logic [XLEN-1:0]       instr_pc;
    logic                  reg_we;
    logic [REG_ADDR_W-1:0] reg_waddr;
    logic [XLEN-1:0]       reg_wdata;
    logic [XLEN-1:0]       alu_result;
    logic                  take_jump;
    logic [XLEN-1:0]       jump_target;
    logic                  pc_load;
    logic [XLEN-1:0]       next_pc;

    exec_if ex_bus ();

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) fetch0 (
        .clk        (clk),
        .reset      (reset),
        .imem_ack   (imem_ack),
        .imem_data  (imem_data),
        .pc_load    (pc_load),
        .next_pc    (next_pc),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .instr_valid(instr_valid),
        .instr      (instr),
        .instr_pc   (instr_pc)
    );

    decode_stage decode0 (
        .clk        (clk),
        .reset      (reset),
        .instr_valid(instr_valid),
        .instr      (instr),
        .instr_pc   (instr_pc),
        .reg_we     (reg_we),
        .reg_waddr  (reg_waddr),
        .reg_wdata  (reg_wdata),
        .ex         (ex_bus)
    );

    alu_unit alu0 (
        .ex        (ex_bus),
        .alu_result(alu_result)
    );

    branch_unit branch0 (
        .ex         (ex_bus),
        .take_jump  (take_jump),
        .jump_target(jump_target)
    );

    writeback_unit wb0 (
        .clk         (clk),
        .reset       (reset),
        .alu_result  (alu_result),
        .take_jump   (take_jump),
        .jump_target (jump_target),
        .ex          (ex_bus),
        .reg_we      (reg_we),
        .reg_waddr   (reg_waddr),
        .reg_wdata   (reg_wdata),
        .pc_load     (pc_load),
        .next_pc     (next_pc),
        .retire_valid(retire_valid),
        .retire_pc   (retire_pc),
        .retire_rd   (retire_rd),
        .retire_we   (retire_we),
        .retire_wdata(retire_wdata)
    );

endmodule

`default_nettype wire

// ==== tests/core_model.svh ====
/* reference model of the kept RV32I subset
   and the random instruction generator behind the memory responder */
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

logic [31:0] ref_regs [32];
logic [31:0] ref_pc;       // pc of the next word the model expects to fetch
logic [31:0] exp_pc;
logic        exp_we;
logic [4:0]  exp_rd;
logic [31:0] exp_wdata;

function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
        3'b000: r = alt ? a - b : a + b;
        3'b001: r = a << b[4:0];
        3'b010: r = {31'b0, $signed(a) < $signed(b)};
        3'b011: r = {31'b0, a < b};
        3'b100: r = a ^ b;
        3'b101: begin
            if (alt) begin
                r = $signed(a) >>> b[4:0];    // arithmetic shift keeps the sign
            end else begin
                r = a >> b[4:0];
            end
        end
        3'b110: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f3)
        3'b000: return a == b;
        3'b001: return a != b;
        3'b100: return $signed(a) < $signed(b);
        3'b101: return $signed(a) >= $signed(b);
        3'b110: return a < b;
        3'b111: return a >= b;
        default: return 1'b0;
    endcase
endfunction

// runs one word on the model state and records the expected retire record
task automatic execute_word(input logic [31:0] w);
    logic [31:0] a, b;
    logic [31:0] imm_i, imm_b, imm_u, imm_j;
    logic [31:0] result;
    logic [31:0] next;
    logic        write;
    a      = ref_regs[w[19:15]];
    b      = ref_regs[w[24:20]];
    imm_i  = {{20{w[31]}}, w[31:20]};
    imm_b  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u  = {w[31:12], 12'h000};
    imm_j  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    next   = ref_pc + 32'd4;
    write  = 1'b0;
    result = 32'd0;
    case (w[6:0])
        OPC_OP: begin
            write  = 1'b1;
            result = alu_model(w[14:12], w[30], a, b);
        end
        OPC_OP_IMM: begin
            write  = 1'b1;
            result = alu_model(w[14:12], w[30] & (w[14:12] == 3'b101), a, imm_i);
        end
        OPC_LUI: begin
            write  = 1'b1;
            result = imm_u;
        end
        OPC_AUIPC: begin
            write  = 1'b1;
            result = ref_pc + imm_u;
        end
        OPC_BRANCH: begin
            if (branch_taken(w[14:12], a, b)) begin
                next = (ref_pc + imm_b) & 32'hffff_fffc;
            end
        end
        OPC_JAL: begin
            write  = 1'b1;
            result = ref_pc + 32'd4;
            next   = (ref_pc + imm_j) & 32'hffff_fffc;
        end
        OPC_JALR: begin
            write  = 1'b1;
            result = ref_pc + 32'd4;
            next   = (a + imm_i) & 32'hffff_fffc;    // base read before the link write
        end
        default: ;    // dropped or unknown opcode retires as a no-op
    endcase
    if (w[11:7] == 5'd0) begin
        write = 1'b0;
    end
    exp_pc    = ref_pc;
    exp_we    = write;
    exp_rd    = w[11:7];
    exp_wdata = result;
    if (write) begin
        ref_regs[w[11:7]] = result;
    end
    ref_pc = next;
endtask

// first 31 words preload x1..x31, then a mix of every kept class
function automatic logic [31:0] random_instr(input int index);
    logic [31:0] r;
    logic [3:0]  kind;
    logic [2:0]  f3;
    logic [6:0]  bad_opc;
    logic [31:0] w;
    r    = $urandom;
    kind = 4'($urandom_range(15, 0));
    f3   = (r[14:13] == 2'b01) ? {2'b00, r[12]} : r[14:12];    // valid branch conditions
    case (r[1:0])
        2'b00:   bad_opc = 7'h03;    // load
        2'b01:   bad_opc = 7'h23;    // store
        2'b10:   bad_opc = 7'h73;    // system
        default: bad_opc = 7'h0b;
    endcase
    if (index < 31) begin
        w = {r[31:20], 5'd0, 3'b000, 5'(index + 1), OPC_OP_IMM};
    end else begin
        case (kind)
            0, 1, 2, 3: begin
                w = {1'b0, r[30] & (r[14:12] == 3'b000 || r[14:12] == 3'b101), 5'b0,
                     r[24:7], OPC_OP};
            end
            4, 5, 6: begin
                if (r[13:12] == 2'b01) begin    // shifts keep funct7 legal
                    w = {1'b0, r[30] & r[14], 5'b0, r[24:7], OPC_OP_IMM};
                end else begin
                    w = {r[31:7], OPC_OP_IMM};
                end
            end
            8:          w = {r[31:7], OPC_AUIPC};
            9, 10, 11:  w = {r[31:15], f3, r[11:9], 1'b0, r[7], OPC_BRANCH};
            12:         w = {r[31:22], 1'b0, r[20:7], OPC_JAL};
            13:         w = {r[31:15], 3'b000, r[11:7], OPC_JALR};
            14:         w = {r[31:7], bad_opc};
            default:    w = {r[31:7], OPC_LUI};
        endcase
    end
    return w;
endfunction

`endif

// ==== tests/tb_rv_core.sv ====
/* rv_core testbench
   random instruction stream from a four-phase memory responder, checked against a model */
`default_nettype none
`timescale 1ns/100ps

module tb_rv_core import rv_pkg::*; ();

    localparam logic [31:0] RESET_PC       = 32'h8000_0000;
    localparam int          NUM_INSTR      = 400;
    localparam int          MAX_ACK_DELAY  = 4;
    localparam int          TIMEOUT_CYCLES = NUM_INSTR * (2 * MAX_ACK_DELAY + 8);

    logic        clk;
    logic        reset;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_ack;
    logic [31:0] imem_data;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic        retire_we;
    logic [31:0] retire_wdata;

    int          cycles;
    int          checks;
    int          errors;
    int          proto_errors;
    int          retired;
    int          issued;
    int          ack_cycle;     // cycle count when ack was raised
    int          wait_left;
    int          resp_state;    // 0 idle, 1 delay, 2 ack high
    int          mark;
    logic        pending;
    logic        prev_req;
    logic        prev_ack;
    logic [31:0] word;

    `include "core_model.svh"

    rv_core #(
        .RESET_PC(RESET_PC)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .imem_ack    (imem_ack),
        .imem_data   (imem_data),
        .retire_valid(retire_valid),
        .retire_pc   (retire_pc),
        .retire_rd   (retire_rd),
        .retire_we   (retire_we),
        .retire_wdata(retire_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // cycle counter that also ends a hung run
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the core stopped retiring at %0d of %0d",
                 cycles, retired, NUM_INSTR);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_problem(input string what);
        errors++;
        proto_errors++;
        $display("%0t %s", $time, what);
    endtask

    task automatic check_retire();
        if (!pending) begin
            report_problem("retire_valid is high with no instruction in flight");
        end
        check_value("retire latency", ack_cycle + 3, cycles);    // three cycles after ack
        check_value("retire_pc", exp_pc, retire_pc);
        check_value("retire_we", 32'(exp_we), 32'(retire_we));
        check_value("retire_rd", 32'(exp_rd), 32'(retire_rd));
        if (exp_we) begin
            check_value("retire_wdata", exp_wdata, retire_wdata);
        end
        pending = 1'b0;
        retired++;
    endtask

    // one falling edge of the four-phase responder
    task automatic serve_memory();
        if (resp_state == 0 && imem_req) begin
            check_value("imem_addr", ref_pc, imem_addr);    // covers branch and jump targets
            wait_left  = $urandom_range(MAX_ACK_DELAY, 0);
            resp_state = 1;
        end
        if (resp_state == 1) begin
            if (wait_left == 0) begin
                word      = random_instr(issued);
                imem_data = word;
                imem_ack  = 1'b1;
                execute_word(word);
                issued++;
                ack_cycle  = cycles;
                pending    = 1'b1;
                wait_left  = $urandom_range(MAX_ACK_DELAY, 0);    // ack hold after req falls
                resp_state = 2;
            end else begin
                wait_left--;
            end
        end else if (resp_state == 2 && !imem_req) begin
            if (wait_left == 0) begin
                imem_ack   = 1'b0;
                resp_state = 0;
            end else begin
                wait_left--;
            end
        end
    endtask

    initial begin
        void'($urandom(97));
        reset        = 1'b1;
        imem_ack     = 1'b0;
        imem_data    = 32'd0;
        checks       = 0;
        errors       = 0;
        proto_errors = 0;
        retired      = 0;
        issued       = 0;
        ack_cycle    = 0;
        wait_left    = 0;
        resp_state   = 0;
        pending      = 1'b0;
        prev_req     = 1'b0;
        prev_ack     = 1'b0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = 32'd0;
        end
        ref_pc = RESET_PC;

        repeat (5) begin
            @(negedge clk);
            check_value("imem_req", 32'd0, 32'(imem_req));
            check_value("retire_valid", 32'd0, 32'(retire_valid));
        end
        reset = 1'b0;
        $display("test reset: %0d errors", errors);
        mark = errors;

        while (retired < NUM_INSTR) begin
            @(negedge clk);
            if (prev_req && !imem_req && !prev_ack) begin
                report_problem("imem_req fell before imem_ack was seen high");
            end
            if (!prev_req && imem_req && prev_ack) begin
                report_problem("imem_req rose while imem_ack was still high");
            end
            if (retire_valid) begin
                check_retire();
                if (retired == 31) begin
                    $display("test register preload: %0d errors", errors - mark);
                    mark = errors;
                end
            end
            serve_memory();
            prev_req = imem_req;
            prev_ack = imem_ack;
        end

        $display("test random program: %0d errors", errors - mark);
        $display("test handshake: %0d errors", proto_errors);
        $display("%0d instructions retired, %0d checks, %0d errors", retired, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
source/rv_pkg.sv
source/exec_if.sv
source/fetch_unit.sv
source/decode_stage.sv
source/alu_unit.sv
source/branch_unit.sv
source/writeback_unit.sv
source/rv_core.sv
+incdir+tests
tests/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_rv_core -f sim.f

output=$(./obj_dir/Vtb_rv_core)
echo "$output"
echo "$output" | grep -qx "NO ERRORS"
